// ==== src/int_div_macros.svh ====
/*
  width and iteration constants for the iterative divider
  include wherever operand, result or counter widths are needed
*/
`ifndef INT_DIV_MACROS_SVH
`define INT_DIV_MACROS_SVH

// operand width, one word
`define INT_DIV_DATA_W 32

// remainder in the upper half, quotient in the lower half
`define INT_DIV_RESULT_W (2 * `INT_DIV_DATA_W)

// one quotient bit per iteration
`define INT_DIV_ITERS 32

// counter holds ITERS-1 down to 0
`define INT_DIV_CNT_W 5

`endif

// ==== src/int_div_pkg.sv ====
/*
  shared types of the divider: function code and controller states
  referenced by scoped name from the datapath, controller and testbench
*/
package int_div_pkg;

  // ----------------------------------------
  // request function code
  // ----------------------------------------

  // one bit in the request message
  typedef enum logic {
    DIV_FN_UNSIGNED = 1'b0,
    DIV_FN_SIGNED   = 1'b1
  } div_fn_e;

  // ----------------------------------------
  // controller states
  // ----------------------------------------

  // idle  waits for a request, rdy high
  // calc  one restoring step per cycle
  // done  result held until the response is taken
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_CALC = 2'd1,
    ST_DONE = 2'd2
  } div_state_e;

endpackage

// ==== src/int_div_dpath.sv ====
/*
  datapath of the iterative divider: operand capture, restoring
  shift-subtract step, iteration counter and result sign fix-up
*/
`include "int_div_macros.svh"

module int_div_dpath (
  input  logic                           clk,
  input  logic                           reset,

  // request message, sampled only on load
  input  logic                           divreq_msg_fn,
  input  logic [`INT_DIV_DATA_W-1:0]     divreq_msg_a,
  input  logic [`INT_DIV_DATA_W-1:0]     divreq_msg_b,

  // strobes from the controller
  input  logic                           load,
  input  logic                           step,

  output logic                           counter_is_zero,
  output logic [`INT_DIV_RESULT_W-1:0]   divresp_msg_result
);

  // ----------------------------------------
  // request decode
  // ----------------------------------------

  int_div_pkg::div_fn_e fn;
  logic                          fn_signed;
  logic                          sign_a;
  logic                          sign_b;
  logic [`INT_DIV_DATA_W-1:0]    mag_a;
  logic [`INT_DIV_DATA_W-1:0]    mag_b;

  // only place where the function code is looked at
  assign fn        = int_div_pkg::div_fn_e'(divreq_msg_fn);
  assign fn_signed = (fn == int_div_pkg::DIV_FN_SIGNED);

  assign sign_a = divreq_msg_a[`INT_DIV_DATA_W-1];
  assign sign_b = divreq_msg_b[`INT_DIV_DATA_W-1];

  // magnitudes, signed operands are negated when below zero
  // most negative number maps onto 32'h80000000 which is its magnitude
  assign mag_a = (fn_signed && sign_a) ? (~divreq_msg_a + 1'b1) : divreq_msg_a;
  assign mag_b = (fn_signed && sign_b) ? (~divreq_msg_b + 1'b1) : divreq_msg_b;

  // ----------------------------------------
  // registers
  // ----------------------------------------

  // rq_reg: remainder in the upper part, quotient shifts in at bit 0
  // dv_reg: divisor magnitude aligned above the quotient half
  logic [`INT_DIV_RESULT_W:0]    rq_reg;
  logic [`INT_DIV_RESULT_W:0]    dv_reg;
  logic [`INT_DIV_CNT_W-1:0]     cnt_reg;

  // sign flags latched at load
  logic                          quot_neg_reg;
  logic                          rem_neg_reg;

  // ----------------------------------------
  // restoring step
  // ----------------------------------------

  logic [`INT_DIV_RESULT_W:0]    rq_shift;
  logic [`INT_DIV_RESULT_W:0]    rq_diff;
  logic                          diff_neg;
  logic [`INT_DIV_RESULT_W:0]    rq_next;

  // shift the partial remainder and quotient left by one
  assign rq_shift = rq_reg << 1;

  // trial subtraction of the aligned divisor
  assign rq_diff  = rq_shift - dv_reg;

  // top bit set means the divisor did not fit
  assign diff_neg = rq_diff[`INT_DIV_RESULT_W];

  always_comb begin
    if (diff_neg) begin
      // restore, quotient bit zero
      rq_next = {rq_shift[`INT_DIV_RESULT_W:1], 1'b0};
    end else begin
      // keep the difference, quotient bit one
      rq_next = {rq_diff[`INT_DIV_RESULT_W:1], 1'b1};
    end
  end

  // ----------------------------------------
  // operand and working registers
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (load) begin
      // dividend magnitude in the low word, zero remainder above
      rq_reg <= {{(`INT_DIV_DATA_W + 1){1'b0}}, mag_a};
      // divisor magnitude lines up with the remainder half
      dv_reg <= {1'b0, mag_b, {`INT_DIV_DATA_W{1'b0}}};
      // quotient sign from the xor of the operand signs
      quot_neg_reg <= fn_signed && (sign_a ^ sign_b);
      // remainder sign follows the dividend
      rem_neg_reg  <= fn_signed && sign_a;
    end else if (step) begin
      rq_reg <= rq_next;
    end
  end

  // ----------------------------------------
  // iteration counter
  // ----------------------------------------

  // preset to ITERS-1 so the step that sees zero is the last one
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_reg <= '0;
    end else if (load) begin
      cnt_reg <= `INT_DIV_CNT_W'(`INT_DIV_ITERS - 1);
    end else if (step) begin
      cnt_reg <= cnt_reg - `INT_DIV_CNT_W'(1);
    end
  end

  assign counter_is_zero = (cnt_reg == '0);

  // ----------------------------------------
  // result sign fix-up
  // ----------------------------------------

  logic [`INT_DIV_DATA_W-1:0]    quot_mag;
  logic [`INT_DIV_DATA_W-1:0]    rem_mag;
  logic [`INT_DIV_DATA_W-1:0]    quot_out;
  logic [`INT_DIV_DATA_W-1:0]    rem_out;

  // magnitudes after the last step
  assign quot_mag = rq_reg[`INT_DIV_DATA_W-1:0];
  assign rem_mag  = rq_reg[`INT_DIV_RESULT_W-1:`INT_DIV_DATA_W];

  // two's complement negate where the latched flags ask for it
  assign quot_out = quot_neg_reg ? (~quot_mag + 1'b1) : quot_mag;
  assign rem_out  = rem_neg_reg  ? (~rem_mag + 1'b1)  : rem_mag;

  // remainder high, quotient low; valid whenever the controller is in done
  assign divresp_msg_result = {rem_out, quot_out};

endmodule

// ==== src/int_div_ctrl.sv ====
/*
  controller of the iterative divider: idle, calc and done states
  drives load and step to the datapath and the val/rdy strobes
*/
module int_div_ctrl (
  input  logic clk,
  input  logic reset,

  // handshake inputs
  input  logic divreq_val,
  input  logic divresp_rdy,

  // end of iteration from the datapath
  input  logic counter_is_zero,

  // handshake outputs
  output logic divreq_rdy,
  output logic divresp_val,

  // datapath strobes
  output logic load,
  output logic step
);

  // ----------------------------------------
  // state register
  // ----------------------------------------

  int_div_pkg::div_state_e state_reg;
  int_div_pkg::div_state_e state_next;

  logic req_go;
  logic resp_go;

  // transfers happen on the edge where both sides agree
  assign req_go  = divreq_val && divreq_rdy;
  assign resp_go = divresp_val && divresp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_reg <= int_div_pkg::ST_IDLE;
    end else begin
      state_reg <= state_next;
    end
  end

  // ----------------------------------------
  // next state
  // ----------------------------------------

  always_comb begin
    state_next = state_reg;
    case (state_reg)
      int_div_pkg::ST_IDLE: begin
        // operands are captured on this same edge
        if (req_go) begin
          state_next = int_div_pkg::ST_CALC;
        end
      end

      int_div_pkg::ST_CALC: begin
        // zero count means this cycle's step is the last
        if (counter_is_zero) begin
          state_next = int_div_pkg::ST_DONE;
        end
      end

      int_div_pkg::ST_DONE: begin
        // hold the result until the response is taken
        if (resp_go) begin
          state_next = int_div_pkg::ST_IDLE;
        end
      end

      default: begin
        state_next = int_div_pkg::ST_IDLE;
      end
    endcase
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------

  // rdy only while idle, so a new request waits one cycle after a response
  assign divreq_rdy  = (state_reg == int_div_pkg::ST_IDLE);

  // result is valid for the whole of done
  assign divresp_val = (state_reg == int_div_pkg::ST_DONE);

  // capture strobe on the accepting edge
  assign load = req_go;

  // one restoring step per calc cycle, 32 in total
  assign step = (state_reg == int_div_pkg::ST_CALC);

endmodule

// ==== src/int_div_iterative.sv ====
/*
  iterative 32-bit divider, top level of the multiply/divide unit's divide side
  joins the controller and the datapath; request and response use val/rdy
*/
`include "int_div_macros.svh"

module int_div_iterative (
  input  logic                           clk,
  input  logic                           reset,

  // request side
  input  logic                           divreq_msg_fn,
  input  logic [`INT_DIV_DATA_W-1:0]     divreq_msg_a,
  input  logic [`INT_DIV_DATA_W-1:0]     divreq_msg_b,
  input  logic                           divreq_val,
  output logic                           divreq_rdy,

  // response side, remainder high and quotient low
  output logic [`INT_DIV_RESULT_W-1:0]   divresp_msg_result,
  output logic                           divresp_val,
  input  logic                           divresp_rdy
);

  // controller to datapath
  logic load;
  logic step;

  // datapath back to controller
  logic counter_is_zero;

  // sequencing and handshake
  int_div_ctrl ctrl0 (
    .clk             (clk),
    .reset           (reset),
    .divreq_val      (divreq_val),
    .divresp_rdy     (divresp_rdy),
    .counter_is_zero (counter_is_zero),
    .divreq_rdy      (divreq_rdy),
    .divresp_val     (divresp_val),
    .load            (load),
    .step            (step)
  );

  // operands, restoring step and sign fix-up
  int_div_dpath dpath0 (
    .clk                (clk),
    .reset              (reset),
    .divreq_msg_fn      (divreq_msg_fn),
    .divreq_msg_a       (divreq_msg_a),
    .divreq_msg_b       (divreq_msg_b),
    .load               (load),
    .step               (step),
    .counter_is_zero    (counter_is_zero),
    .divresp_msg_result (divresp_msg_result)
  );

endmodule

// ==== tb/int_div_chk.sv ====
/*
  protocol and timing assertions on the divider top level
  attached to int_div_iterative by the bind at the bottom
*/
`include "int_div_macros.svh"

module int_div_chk (
  input logic                         clk,
  input logic                         reset,
  input logic                         divreq_val,
  input logic                         divreq_rdy,
  input logic                         divresp_val,
  input logic                         divresp_rdy,
  input logic [`INT_DIV_RESULT_W-1:0] divresp_msg_result,
  input logic                         load,
  input logic                         step
);

  int_div_pkg::div_state_e st;
  logic                    req_go;

  // controller state as seen from the handshake outputs
  always_comb begin
    if (divreq_rdy) begin
      st = int_div_pkg::ST_IDLE;
    end else if (divresp_val) begin
      st = int_div_pkg::ST_DONE;
    end else begin
      st = int_div_pkg::ST_CALC;
    end
  end

  assign req_go = divreq_val && divreq_rdy;

  // ----------------------------------------
  // assertions
  // ----------------------------------------

  rdy_val_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(divreq_rdy && divresp_val))
    else $error("divreq_rdy and divresp_val were high together");

  // still calculating on the 32nd edge after acceptance
  calc_through_last_step: assert property (@(posedge clk) disable iff (reset)
    req_go |-> ##32 (st == int_div_pkg::ST_CALC))
    else $error("divider left calc before the last step");

  resp_after_iters: assert property (@(posedge clk) disable iff (reset)
    req_go |-> ##33 (st == int_div_pkg::ST_DONE))
    else $error("response did not appear 32 cycles after acceptance");

  hold_under_backpressure: assert property (@(posedge clk) disable iff (reset)
    (st == int_div_pkg::ST_DONE && !divresp_rdy) |=>
      (st == int_div_pkg::ST_DONE && $stable(divresp_msg_result)))
    else $error("response changed while divresp_rdy was low");

  strobes_quiet_in_reset: assert property (@(posedge clk)
    (reset && $past(reset)) |-> (!load && !step))
    else $error("load or step active during reset");

endmodule

bind int_div_iterative int_div_chk chk0 (
  .clk                (clk),
  .reset              (reset),
  .divreq_val         (divreq_val),
  .divreq_rdy         (divreq_rdy),
  .divresp_val        (divresp_val),
  .divresp_rdy        (divresp_rdy),
  .divresp_msg_result (divresp_msg_result),
  .load               (load),
  .step               (step)
);

// ==== tb/tb_int_div.sv ====
/*
  testbench for the iterative divider with LCG driven requests
  a reference model of the restoring divide rules and value and handshake checks
*/
`include "int_div_macros.svh"

module tb_int_div;

  // ----------------------------------------
  // run length
  // ----------------------------------------

  localparam int RESET_CYCLES   = 10;
  localparam int NUM_TESTS      = 5;
  localparam int DIVS_PER_TEST  = 80;
  // gap 3 + accept 1 + calc 32 + hold 3 + response 1
  localparam int CYCLES_PER_DIV = 40;
  // every division at its worst case plus the one left pending at the
  // second reset, two resets and a little slack on top
  localparam int TIMEOUT_CYCLES = (NUM_TESTS * DIVS_PER_TEST + 1) * CYCLES_PER_DIV
                                  + 2 * RESET_CYCLES + 16;

  logic                         clk;
  logic                         reset;
  logic                         divreq_msg_fn;
  logic [`INT_DIV_DATA_W-1:0]   divreq_msg_a;
  logic [`INT_DIV_DATA_W-1:0]   divreq_msg_b;
  logic                         divreq_val;
  logic                         divreq_rdy;
  logic [`INT_DIV_RESULT_W-1:0] divresp_msg_result;
  logic                         divresp_val;
  logic                         divresp_rdy;

  logic [31:0] lcg_state = 32'h3a6a20eb;
  int          cycle_count = 0;
  int          test_errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;

  int_div_iterative dut0 (
    .clk                (clk),
    .reset              (reset),
    .divreq_msg_fn      (divreq_msg_fn),
    .divreq_msg_a       (divreq_msg_a),
    .divreq_msg_b       (divreq_msg_b),
    .divreq_val         (divreq_val),
    .divreq_rdy         (divreq_rdy),
    .divresp_msg_result (divresp_msg_result),
    .divresp_val        (divresp_val),
    .divresp_rdy        (divresp_rdy)
  );

  always #5 clk = ~clk;

  // global cycle limit on the whole run
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the divider stopped answering after %0d cycles", cycle_count);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // ----------------------------------------
  // random numbers and operands
  // ----------------------------------------

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // upper bits only since the low LCG bits repeat quickly
  function automatic int random_span();
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:30]);
  endfunction

  // zero, minus one, most negative and small values show up often
  function automatic logic [31:0] pick_operand();
    logic [31:0] sel;
    logic [31:0] r;
    sel = next_rand();
    r   = next_rand();
    case (sel[31:29])
      3'd0:    return 32'h0000_0000;
      3'd1:    return 32'hffff_ffff;
      3'd2:    return 32'h8000_0000;
      3'd3:    return {28'h0, r[31:28]};
      3'd4:    return {16'h0, r[31:16]};
      default: return r;
    endcase
  endfunction

  // ----------------------------------------
  // reference model
  // ----------------------------------------

  // divide magnitudes, then apply the sign rules; zero divisor
  // gives all ones and the dividend magnitude before the fix-up
  function automatic logic [63:0] divide_model(input int_div_pkg::div_fn_e fn,
                                               input logic [31:0] a,
                                               input logic [31:0] b);
    logic        neg_a;
    logic        neg_b;
    logic [31:0] mag_a;
    logic [31:0] mag_b;
    logic [31:0] q;
    logic [31:0] r;
    neg_a = (fn == int_div_pkg::DIV_FN_SIGNED) && a[31];
    neg_b = (fn == int_div_pkg::DIV_FN_SIGNED) && b[31];
    mag_a = neg_a ? (32'd0 - a) : a;
    mag_b = neg_b ? (32'd0 - b) : b;
    if (mag_b == 32'd0) begin
      q = 32'hffff_ffff;
      r = mag_a;
    end else begin
      q = mag_a / mag_b;
      r = mag_a % mag_b;
    end
    if (neg_a ^ neg_b) begin
      q = 32'd0 - q;
    end
    if (neg_a) begin
      r = 32'd0 - r;
    end
    return {r, q};
  endfunction

  // ----------------------------------------
  // checks and sequencing helpers
  // ----------------------------------------

  task automatic check_value(input string test_name, input string what,
                             input logic [63:0] expected, input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("Fail %s %s expected %h actual %h", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_true(input string test_name, input logic cond, input string msg);
    assert (cond === 1'b1) else begin
      $display("%s: %s", test_name, msg);
      test_errors++;
    end
  endtask

  // inputs change 1 unit after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic apply_reset();
    reset       = 1'b1;
    divreq_val  = 1'b0;
    divresp_rdy = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  // leave a response waiting in done and reset over it
  task automatic reset_over_response();
    logic [31:0] r;
    r = next_rand();
    divreq_msg_fn = int_div_pkg::DIV_FN_UNSIGNED;
    divreq_msg_a  = r;
    divreq_msg_b  = {16'h0, r[15:0]};
    divreq_val    = 1'b1;
    next_cycle();
    divreq_val = 1'b0;
    while (divresp_val !== 1'b1) begin
      next_cycle();
    end
    apply_reset();
  endtask

  // one request/response pair with an idle gap and response back-pressure
  task automatic run_division(input string test_name, input int_div_pkg::div_fn_e fn,
                              input logic [31:0] a, input logic [31:0] b,
                              input int gap, input int hold);
    logic [63:0] expected;
    logic [63:0] seen;
    logic [31:0] junk;
    int          latency;
    expected = divide_model(fn, a, b);
    repeat (gap) next_cycle();
    check_true(test_name, divreq_rdy, "divider was not ready for a new request");
    divreq_msg_fn = fn;
    divreq_msg_a  = a;
    divreq_msg_b  = b;
    divreq_val    = 1'b1;
    next_cycle();
    // operands were captured on the accepting edge and can be scrambled now
    junk          = next_rand();
    divreq_val    = 1'b0;
    divreq_msg_a  = junk;
    divreq_msg_b  = ~junk;
    latency       = 0;
    while (divresp_val !== 1'b1) begin
      check_true(test_name, !divreq_rdy, "a request was taken while a division was running");
      next_cycle();
      latency++;
    end
    check_value(test_name, "latency", 64'(`INT_DIV_ITERS), 64'(latency));
    seen = divresp_msg_result;
    check_value(test_name, "result", expected, seen);
    if (fn == int_div_pkg::DIV_FN_UNSIGNED && b != 32'd0) begin
      check_true(test_name, seen[63:32] < b, "remainder is not below the divisor");
    end
    // nonzero remainder carries the dividend's sign
    if (fn == int_div_pkg::DIV_FN_SIGNED && seen[63:32] != 32'd0) begin
      check_true(test_name, seen[63] == a[31], "remainder sign differs from the dividend");
    end
    repeat (hold) begin
      next_cycle();
      check_true(test_name, divresp_val, "response was withdrawn before it was taken");
      check_true(test_name, !divreq_rdy, "request side became ready under back-pressure");
      check_value(test_name, "held result", seen, divresp_msg_result);
    end
    divresp_rdy = 1'b1;
    next_cycle();
    divresp_rdy = 1'b0;
    check_true(test_name, !divresp_val, "response was offered again after it was taken");
  endtask

  task automatic finish_test(input string test_name);
    if (test_errors == 0) begin
      tests_passed++;
    end else begin
      tests_failed++;
    end
    $display("test %s: %0d divisions, %0d errors", test_name, DIVS_PER_TEST, test_errors);
    test_errors = 0;
  endtask

  // test_id picks the function, operand classes and back-pressure
  task automatic run_test(input string test_name, input int test_id);
    int_div_pkg::div_fn_e fn;
    logic [31:0]          a;
    logic [31:0]          b;
    logic [31:0]          r;
    int                   hold;
    for (int i = 0; i < DIVS_PER_TEST; i++) begin
      r    = next_rand();
      fn   = int_div_pkg::div_fn_e'(r[31]);
      a    = pick_operand();
      b    = pick_operand();
      hold = random_span();
      case (test_id)
        0: fn = int_div_pkg::DIV_FN_UNSIGNED;
        1: fn = int_div_pkg::DIV_FN_SIGNED;
        2: begin
          case (i % 5)
            0: begin
              fn = int_div_pkg::DIV_FN_UNSIGNED;
              b  = 32'h0;
            end
            1: begin
              fn = int_div_pkg::DIV_FN_SIGNED;
              b  = 32'h0;
            end
            2: begin
              fn = int_div_pkg::DIV_FN_SIGNED;
              a  = 32'h8000_0000;
              b  = 32'hffff_ffff;
            end
            3: begin
              // small positive dividend under a large positive divisor
              a = {24'h0, r[7:0]};
              b = {1'b0, r[30:0]} | 32'h0100_0000;
            end
            default: b = 32'h1;
          endcase
        end
        // always at least one cycle of back-pressure
        3: hold = 1 + (hold % 3);
        default: begin
        end
      endcase
      run_division(test_name, fn, a, b, random_span(), hold);
    end
    finish_test(test_name);
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    clk           = 1'b0;
    reset         = 1'b1;
    divreq_msg_fn = 1'b0;
    divreq_msg_a  = '0;
    divreq_msg_b  = '0;
    divreq_val    = 1'b0;
    divresp_rdy   = 1'b0;
    apply_reset();
    run_test("unsigned_random", 0);
    run_test("signed_random", 1);
    run_test("corner_values", 2);
    run_test("backpressure", 3);
    // second reset over a pending response, then the idle outputs
    reset_over_response();
    check_true("latency_and_reset", divreq_rdy, "divreq_rdy is not high right after reset");
    check_true("latency_and_reset", !divresp_val, "divresp_val is not low right after reset");
    run_test("latency_and_reset", 4);
    $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+src
src/int_div_pkg.sv
src/int_div_dpath.sv
src/int_div_ctrl.sv
src/int_div_iterative.sv
tb/int_div_chk.sv
tb/tb_int_div.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := tb_int_div
FILELIST  := sim.f
VFLAGS    := --binary --timing --assert
LINTFLAGS := --lint-only --timing
OBJDIR    := obj_dir
LOG       := sim.log
FAIL_MSG  := *** FAILED ***
PASS_MSG  := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
